//--- source/fetch_cfg_pkg.sv
// ========================================
// Sizes, start address and width types of
// the two-wide fetch front end
// ========================================
package fetch_cfg_pkg;

	// ========================================
	// Block geometry
	// ========================================
	// Two slots per aligned eight byte block
	localparam int FETCH_WIDTH = 2;
	localparam int BLOCK_BYTES = 4 * FETCH_WIDTH;

	// Direct mapped target table, indexed by word address bits
	localparam int LPHT_ADDR_WIDTH = 4;
	localparam int LPHT_DEPTH      = 1 << LPHT_ADDR_WIDTH;

	// Return stack, only the pointer is modelled
	localparam int RAS_DEPTH     = 8;
	localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH);

	// Major opcode range of jirl, b, bl and the conditional branches
	localparam logic [5:0] BR_OPC_LO = 6'h13;
	localparam logic [5:0] BR_OPC_HI = 6'h1b;

	// ========================================
	// Width types
	// ========================================
	typedef logic [31:0]                addr_t;
	typedef logic [31:0]                inst_t;
	typedef inst_t [FETCH_WIDTH-1:0]    inst_pair_t;
	typedef logic [LPHT_ADDR_WIDTH-1:0] lpht_idx_t;
	typedef logic [RAS_PTR_WIDTH-1:0]   ras_ptr_t;
	typedef logic [FETCH_WIDTH-1:0]     slot_mask_t;

	// First fetch address after reset
	localparam addr_t RESET_PC = 32'h1c00_0000;

endpackage

//--- source/fetch_types_pkg.sv
// ========================================
// Bundles passed between the fetch stages
// and from the front end toward decode
// ========================================
package fetch_types_pkg;

	import fetch_cfg_pkg::*;

	// Prediction for one fetch block
	typedef struct packed {
		logic     taken;
		// Slot that holds the predicted branch
		logic     br_idx;
		addr_t    target;
		// Return stack pointer at lookup time
		ras_ptr_t ras_ptr;
	} br_info_t;

	// Contents of the F2 stage
	typedef struct packed {
		// Block aligned address
		addr_t      pc;
		inst_pair_t inst;
		slot_mask_t valid;
		br_info_t   br_info;
	} fetch_block_t;

	// Fix-up raised by the pre-checker on a false taken prediction
	typedef struct packed {
		logic      redirect;
		// Address of the slot that missed
		addr_t     pc;
		// Where fetch resumes, the next sequential word
		addr_t     target;
		ras_ptr_t  ras_ptr;
		// Table entry to drop
		lpht_idx_t lpht_idx;
	} precheck_fix_t;

	// Packet handed to decode
	typedef struct packed {
		addr_t      pc;
		inst_pair_t inst;
		slot_mask_t valid;
		slot_mask_t branch;
		// Prediction survived the pre-check
		logic       taken;
		addr_t      target;
	} decode_packet_t;

endpackage

//--- source/fetch_pc_gen.sv
// ========================================
// Fetch PC register and next-PC select
// Drives the aligned block address to the
// instruction memory plus a slot start mask
// ========================================
`timescale 1ns/1ps

module fetch_pc_gen (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           stall_i,
	input  logic                           bk_redirect_i,
	input  fetch_cfg_pkg::addr_t           bk_target_i,
	input  fetch_types_pkg::precheck_fix_t fix_i,
	input  fetch_types_pkg::br_info_t      pred_i,
	output fetch_cfg_pkg::addr_t           pc_o,
	output fetch_cfg_pkg::slot_mask_t      start_mask_o
);

	import fetch_cfg_pkg::*;

	// Word address of the next instruction to fetch
	addr_t pc_q;
	addr_t block_pc;
	addr_t next_pc;

	// Drop the in-block offset
	assign block_pc = pc_q & ~addr_t'(BLOCK_BYTES - 1);

	// Next PC by priority
	always_comb begin
		if (bk_redirect_i) begin
			next_pc = bk_target_i;
		end else if (fix_i.redirect) begin
			next_pc = fix_i.target;
		end else if (pred_i.taken) begin
			next_pc = pred_i.target;
		end else begin
			next_pc = block_pc + addr_t'(BLOCK_BYTES);
		end
	end

	// Backend redirect still moves the PC during a stall
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else if (bk_redirect_i || !stall_i) begin
			pc_q <= next_pc;
		end
	end

	assign pc_o = block_pc;

	// Slots ahead of the entry slot are not fetched
	always_comb begin
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			start_mask_o[i] = (i >= int'(pc_q[2]));
		end
	end

	// Redirect targets from outside must land on a word
	a_pc_word_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
		pc_q[1:0] == 2'b00)
		else $error("fetch_pc_gen misaligned pc %h", pc_q);

endmodule

//--- source/branch_predictor.sv
// ========================================
// Direct mapped branch target table and
// speculative return stack pointer
// Lookup result is registered into F2
// ========================================
`timescale 1ns/1ps

module branch_predictor (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           stall_i,
	input  logic                           flush_i,
	input  fetch_cfg_pkg::addr_t           pc_i,
	input  logic                           train_i,
	input  fetch_cfg_pkg::addr_t           train_pc_i,
	input  fetch_cfg_pkg::addr_t           train_target_i,
	input  logic                           call_i,
	input  logic                           ret_i,
	input  fetch_types_pkg::precheck_fix_t fix_i,
	output fetch_types_pkg::br_info_t      pred_o
);

	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	// One table entry, always predicts taken
	typedef struct packed {
		logic  slot;
		addr_t target;
	} lpht_entry_t;

	logic [LPHT_DEPTH-1:0] lpht_valid_q;
	lpht_entry_t           lpht_q [LPHT_DEPTH];
	lpht_idx_t             train_idx;
	ras_ptr_t              ras_ptr_q;
	ras_ptr_t              ras_ptr_d;
	br_info_t              lookup;
	br_info_t              pred_q;

	// ========================================
	// Table update
	// ========================================
	assign train_idx = train_pc_i[LPHT_ADDR_WIDTH+1:2];

	// Drop a false entry
	// Training write on the same index wins
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			lpht_valid_q <= '0;
		end else begin
			if (fix_i.redirect) begin
				lpht_valid_q[fix_i.lpht_idx] <= 1'b0;
			end
			if (train_i) begin
				lpht_valid_q[train_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (train_i) begin
			lpht_q[train_idx] <= '{slot: train_pc_i[2], target: train_target_i};
		end
	end

	// ========================================
	// Lookup of both slots
	// ========================================
	always_comb begin
		addr_t     slot_pc;
		lpht_idx_t idx;
		lookup         = '0;
		lookup.ras_ptr = ras_ptr_d;
		// Walk downward so the lower slot wins
		for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
			slot_pc = pc_i + addr_t'(4 * i);
			idx     = slot_pc[LPHT_ADDR_WIDTH+1:2];
			if (lpht_valid_q[idx]) begin
				lookup.taken  = 1'b1;
				lookup.br_idx = lpht_q[idx].slot;
				lookup.target = lpht_q[idx].target;
			end
		end
	end

	// Return stack pointer
	// Restore beats backend strobes
	always_comb begin
		ras_ptr_d = ras_ptr_q;
		if (fix_i.redirect) begin
			ras_ptr_d = fix_i.ras_ptr;
		end else if (call_i) begin
			ras_ptr_d = ras_ptr_q + ras_ptr_t'(1);
		end else if (ret_i) begin
			ras_ptr_d = ras_ptr_q - ras_ptr_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ras_ptr_q <= '0;
		end else begin
			ras_ptr_q <= ras_ptr_d;
		end
	end

	// Prediction for the block now in F2
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pred_q <= '0;
		end else if (flush_i) begin
			pred_q.taken   <= 1'b0;
			pred_q.ras_ptr <= ras_ptr_d;
		end else if (!stall_i) begin
			pred_q <= lookup;
		end
	end

	assign pred_o = pred_q;

	// Backend retires one control transfer per cycle
	a_call_ret_excl : assert property (@(posedge clk) disable iff (!rst_n_i)
		!(call_i && ret_i))
		else $error("branch_predictor call and return in the same cycle");

endmodule

//--- source/predecoder.sv
// ========================================
// Marks the valid slots of a fetch block
// that hold branch or jump instructions
// ========================================
`timescale 1ns/1ps

module predecoder (
	input  fetch_types_pkg::fetch_block_t block_i,
	output fetch_cfg_pkg::slot_mask_t     branch_o
);

	import fetch_cfg_pkg::*;

	// LoongArch major opcodes, bits 31 to 26
	//   13 jirl
	//   14 b
	//   15 bl
	//   16 to 1b beq bne blt bge bltu bgeu
	// Everything in between is a control transfer
	always_comb begin
		logic [5:0] opc;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			opc = block_i.inst[i][31:26];
			// Invalid slots never count as branches
			branch_o[i] = block_i.valid[i]
				&& (opc >= BR_OPC_LO)
				&& (opc <= BR_OPC_HI);
		end
	end

endmodule

//--- source/pre_checker.sv
// ========================================
// Pre-check of the F2 prediction against
// predecode, raises a fix-up on a taken
// prediction that hit a plain instruction
// ========================================
`timescale 1ns/1ps

module pre_checker (
	input  fetch_types_pkg::fetch_block_t  block_i,
	input  fetch_cfg_pkg::slot_mask_t      branch_i,
	input  logic                           stall_i,
	output fetch_types_pkg::precheck_fix_t fix_o,
	output fetch_cfg_pkg::slot_mask_t      valid_o
);

	import fetch_cfg_pkg::*;

	// Valid slot the predictor claimed as taken
	slot_mask_t pred_slot;
	// Claimed slot is not a branch at all
	slot_mask_t miss;

	always_comb begin
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			pred_slot[i] = block_i.br_info.taken
				&& (block_i.br_info.br_idx == i[0])
				&& block_i.valid[i];
			miss[i] = pred_slot[i] && !branch_i[i];
		end
	end

	// ========================================
	// Fix-up toward PC gen and predictor
	// ========================================
	always_comb begin
		addr_t slot_pc;
		fix_o = '0;
		// Held block is checked again once the stall drops
		fix_o.redirect = (|miss) && !stall_i;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			slot_pc = block_i.pc + addr_t'(4 * i);
			if (miss[i]) begin
				fix_o.pc       = slot_pc;
				fix_o.target   = slot_pc + addr_t'(4);
				fix_o.ras_ptr  = block_i.br_info.ras_ptr;
				fix_o.lpht_idx = slot_pc[LPHT_ADDR_WIDTH+1:2];
			end
		end
	end

	// Slots after a claimed taken slot are cut
	// Applies to a confirmed branch as well as a miss
	always_comb begin
		logic cut;
		cut = 1'b0;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			valid_o[i] = block_i.valid[i] && !cut;
			cut        = cut || pred_slot[i];
		end
	end

	// Predecode flags only slots that were fetched
	always_comb begin
		a_branch_in_valid : assert final ((branch_i & ~block_i.valid) == '0)
			else $error("pre_checker branch flagged on invalid slot %b", branch_i);
	end

endmodule

//--- source/fetch_buffer.sv
// ========================================
// Output register toward decode
// Holds on stall, empties on flush
// ========================================
`timescale 1ns/1ps

module fetch_buffer (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            stall_i,
	input  logic                            flush_i,
	input  fetch_types_pkg::fetch_block_t   block_i,
	input  fetch_cfg_pkg::slot_mask_t       branch_i,
	input  fetch_cfg_pkg::slot_mask_t       valid_i,
	input  logic                            taken_ok_i,
	output fetch_types_pkg::decode_packet_t dec_packet_o
);

	import fetch_cfg_pkg::*;

	// Control part
	slot_mask_t valid_q;
	slot_mask_t branch_q;
	logic       taken_q;
	// Payload part
	addr_t      pc_q;
	addr_t      target_q;
	inst_pair_t inst_q;
	logic       load;

	// Payload only moves for a block with something in it
	assign load = !stall_i && (|valid_i);

	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			valid_q  <= '0;
			branch_q <= '0;
			taken_q  <= 1'b0;
		end else if (!stall_i) begin
			valid_q  <= valid_i;
			branch_q <= branch_i & valid_i;
			taken_q  <= taken_ok_i && (|valid_i);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pc_q     <= block_i.pc;
			inst_q   <= block_i.inst;
			target_q <= block_i.br_info.target;
		end
	end

	always_comb begin
		dec_packet_o.pc     = pc_q;
		dec_packet_o.inst   = inst_q;
		dec_packet_o.valid  = valid_q;
		dec_packet_o.branch = branch_q;
		dec_packet_o.taken  = taken_q;
		dec_packet_o.target = target_q;
	end

endmodule

//--- source/fetch_frontend.sv
// ========================================
// Two-wide fetch front end top level
// F1 addresses memory and predictor, F2
// predecodes and checks, then to decode
// ========================================
`timescale 1ns/1ps

module fetch_frontend (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  fetch_cfg_pkg::inst_pair_t       imem_data_i,
	input  logic                            stall_i,
	input  logic                            bk_redirect_i,
	input  fetch_cfg_pkg::addr_t            bk_target_i,
	input  logic                            bk_train_i,
	input  fetch_cfg_pkg::addr_t            bk_train_pc_i,
	input  fetch_cfg_pkg::addr_t            bk_train_target_i,
	input  logic                            bk_call_i,
	input  logic                            bk_ret_i,
	output fetch_cfg_pkg::addr_t            imem_addr_o,
	output fetch_types_pkg::decode_packet_t dec_packet_o,
	output fetch_cfg_pkg::ras_ptr_t         ras_ptr_o
);

	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	addr_t         pc;
	slot_mask_t    start_mask;
	br_info_t      pred;
	br_info_t      pred_ok;
	precheck_fix_t fix;
	slot_mask_t    branch;
	slot_mask_t    checked_valid;
	logic          taken_ok;
	// Block in F1 is on the wrong path
	logic          f1_squash;

	// F2 register
	addr_t         f2_pc_q;
	slot_mask_t    f2_valid_q;
	inst_pair_t    held_inst_q;
	logic          hold_q;
	fetch_block_t  f2_block;

	fetch_pc_gen u_pc_gen (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_i       (stall_i),
		.bk_redirect_i (bk_redirect_i),
		.bk_target_i   (bk_target_i),
		.fix_i         (fix),
		.pred_i        (pred_ok),
		.pc_o          (pc),
		.start_mask_o  (start_mask)
	);

	branch_predictor u_bpu (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.stall_i        (stall_i),
		.flush_i        (bk_redirect_i || f1_squash),
		.pc_i           (pc),
		.train_i        (bk_train_i),
		.train_pc_i     (bk_train_pc_i),
		.train_target_i (bk_train_target_i),
		.call_i         (bk_call_i),
		.ret_i          (bk_ret_i),
		.fix_i          (fix),
		.pred_o         (pred)
	);

	// ========================================
	// F2 register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n_i || bk_redirect_i) begin
			f2_valid_q <= '0;
		end else if (!stall_i) begin
			f2_valid_q <= f1_squash ? '0 : start_mask;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			f2_pc_q <= pc;
		end
	end

	// Memory keeps reading the held PC, so keep the F2 words aside
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hold_q <= 1'b0;
		end else begin
			hold_q <= stall_i;
		end
	end

	always_ff @(posedge clk) begin
		if (stall_i && !hold_q) begin
			held_inst_q <= imem_data_i;
		end
	end

	always_comb begin
		f2_block.pc      = f2_pc_q;
		f2_block.inst    = hold_q ? held_inst_q : imem_data_i;
		f2_block.valid   = f2_valid_q;
		f2_block.br_info = pred;
	end

	predecoder u_predecode (
		.block_i  (f2_block),
		.branch_o (branch)
	);

	pre_checker u_precheck (
		.block_i  (f2_block),
		.branch_i (branch),
		.stall_i  (stall_i),
		.fix_o    (fix),
		.valid_o  (checked_valid)
	);

	// Prediction stands only on a valid real branch
	assign taken_ok  = pred.taken && branch[pred.br_idx];
	assign f1_squash = fix.redirect || (taken_ok && !stall_i);

	always_comb begin
		pred_ok       = pred;
		pred_ok.taken = taken_ok;
	end

	fetch_buffer u_fetch_buf (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.flush_i      (bk_redirect_i),
		.block_i      (f2_block),
		.branch_i     (branch),
		.valid_i      (checked_valid),
		.taken_ok_i   (taken_ok),
		.dec_packet_o (dec_packet_o)
	);

	assign imem_addr_o = pc;
	// Pointer as sampled alongside the F2 prediction
	assign ras_ptr_o   = pred.ras_ptr;

endmodule

//--- test/tb_fetch_tasks.svh
// ========================================
// Directed tests of the fetch front end and
// the reference model of decode packets
// ========================================
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

// Major opcodes 13 to 1b are control transfers
function automatic logic is_branch(inst_t w);
	return (w[31:26] >= 6'h13) && (w[31:26] <= 6'h1b);
endfunction

// Random filler kept out of the branch range, branches at chosen words
task automatic load_program();
	inst_t w;
	for (int i = 0; i < 256; i++) begin
		w = $random(seed);
		if (is_branch(w)) begin
			w[31] = 1'b1;
		end
		mem[i] = w;
	end
	mem[8'h03] = {6'h16, 26'h0000c40};
	mem[BR_PC[9:2]] = {6'h15, 26'h0001040};
	mem[8'hc5] = {6'h13, 26'h0000021};
endtask

// ========================================
// Reference model
// ========================================
// Packet expected when fetch enters at entry_pc, with an optional table hit
function automatic decode_packet_t model_packet(addr_t entry_pc, logic hit,
		logic hit_slot, addr_t hit_target);
	decode_packet_t p;
	logic           cut;
	logic           br;
	p    = '0;
	p.pc = entry_pc & ~addr_t'(7);
	cut  = 1'b0;
	for (int i = 0; i < 2; i++) begin
		p.inst[i]   = mem[p.pc[9:2] + 8'(i)];
		p.valid[i]  = (i >= int'(entry_pc[2])) && !cut;
		br          = is_branch(p.inst[i]);
		p.branch[i] = p.valid[i] && br;
		// Slot after a claimed taken slot never reaches decode
		if (hit && (hit_slot == i[0]) && p.valid[i]) begin
			cut     = 1'b1;
			p.taken = br;
		end
	end
	p.target = hit_target;
	return p;
endfunction

task automatic check_value(string name, logic [159:0] got, logic [159:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("ERROR %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic check_packet(decode_packet_t got, decode_packet_t exp);
	check_value("dec_packet_o.pc", 160'(got.pc), 160'(exp.pc));
	check_value("dec_packet_o.valid", 160'(got.valid), 160'(exp.valid));
	check_value("dec_packet_o.inst", 160'(got.inst), 160'(exp.inst));
	check_value("dec_packet_o.branch", 160'(got.branch), 160'(exp.branch));
	check_value("dec_packet_o.taken", 160'(got.taken), 160'(exp.taken));
	if (exp.taken) begin
		check_value("dec_packet_o.target", 160'(got.target), 160'(exp.target));
	end
endtask

// Next packet with at least one valid slot
task automatic wait_packet(output decode_packet_t pkt);
	for (int n = 0; n < PKT_WAIT; n++) begin
		@(negedge clk);
		if (dec_packet_o.valid != '0) begin
			break;
		end
	end
	pkt = dec_packet_o;
	checks++;
	assert (pkt.valid != '0) else begin
		$display("No packet reached decode within %0d cycles", PKT_WAIT);
		errors++;
	end
endtask

task automatic expect_packet(addr_t entry_pc, logic hit, logic hit_slot, addr_t hit_target);
	decode_packet_t got;
	wait_packet(got);
	check_packet(got, model_packet(entry_pc, hit, hit_slot, hit_target));
endtask

// One cycle redirect pulse, optionally with a training write
task automatic redirect_to(addr_t target, logic train, addr_t train_pc, addr_t train_target);
	bk_redirect_i     = 1'b1;
	bk_target_i       = target;
	bk_train_i        = train;
	bk_train_pc_i     = train_pc;
	bk_train_target_i = train_target;
	@(negedge clk);
	bk_redirect_i = 1'b0;
	bk_train_i    = 1'b0;
endtask

// ========================================
// Directed tests
// ========================================
task automatic sequential_fetch();
	expect_packet(RESET_PC, 1'b0, 1'b0, '0);
	expect_packet(RESET_PC + 32'h8, 1'b0, 1'b0, '0);
	expect_packet(RESET_PC + 32'h10, 1'b0, 1'b0, '0);
endtask

task automatic taken_prediction();
	decode_packet_t got;
	int             k;
	redirect_to(BR_PC, 1'b1, BR_PC, BR_TARGET);
	expect_packet(BR_PC, 1'b1, 1'b0, BR_TARGET);
	expect_packet(BR_TARGET, 1'b0, 1'b0, '0);
	expect_packet(RESET_PC + 32'h208, 1'b0, 1'b0, '0);
	// Untagged table aliases onto a plain word further on
	k = 0;
	wait_packet(got);
	while ((got.pc != ALIAS_PC) && (k < 12)) begin
		wait_packet(got);
		k++;
	end
	check_packet(got, model_packet(ALIAS_PC, 1'b1, 1'b0, '0));
	expect_packet(ALIAS_PC + 32'h4, 1'b0, 1'b0, '0);
endtask

task automatic false_taken_drop();
	redirect_to(PLAIN_PC, 1'b1, PLAIN_PC, RESET_PC + 32'h300);
	expect_packet(PLAIN_PC, 1'b1, 1'b0, '0);
	expect_packet(PLAIN_PC + 32'h4, 1'b0, 1'b0, '0);
	// Entry is gone on the second pass
	redirect_to(PLAIN_PC, 1'b0, '0, '0);
	expect_packet(PLAIN_PC, 1'b0, 1'b0, '0);
endtask

task automatic ras_pointer_restore();
	ras_ptr_t snapshot;
	bk_call_i = 1'b1;
	repeat (3) begin
		@(negedge clk);
		ras_model = ras_model + 1'b1;
	end
	bk_call_i = 1'b0;
	bk_ret_i  = 1'b1;
	@(negedge clk);
	ras_model = ras_model - 1'b1;
	bk_ret_i  = 1'b0;
	repeat (2) @(negedge clk);
	check_value("ras_ptr_o", 160'(ras_ptr_o), 160'(ras_model));
	redirect_to(SNAP_PC, 1'b1, SNAP_PC, RESET_PC + 32'h3f0);
	check_value("imem_addr_o", 160'(imem_addr_o), 160'(SNAP_PC));
	@(negedge clk);
	// False taken block sits in F2 with the older snapshot
	snapshot  = ras_model;
	stall_i   = 1'b1;
	bk_call_i = 1'b1;
	repeat (2) begin
		@(negedge clk);
		ras_model = ras_model + 1'b1;
	end
	bk_call_i = 1'b0;
	repeat (2) @(negedge clk);
	stall_i = 1'b0;
	expect_packet(SNAP_PC, 1'b1, 1'b0, '0);
	ras_model = snapshot;
	repeat (2) @(negedge clk);
	check_value("ras_ptr_o", 160'(ras_ptr_o), 160'(ras_model));
endtask

task automatic stall_hold();
	decode_packet_t snap;
	redirect_to(RESET_PC + 32'h20, 1'b0, '0, '0);
	expect_packet(RESET_PC + 32'h20, 1'b0, 1'b0, '0);
	stall_i = 1'b1;
	snap    = dec_packet_o;
	repeat (5) begin
		@(negedge clk);
		check_value("dec_packet_o", 160'(dec_packet_o), 160'(snap));
	end
	stall_i = 1'b0;
	expect_packet(RESET_PC + 32'h28, 1'b0, 1'b0, '0);
	expect_packet(RESET_PC + 32'h30, 1'b0, 1'b0, '0);
endtask

task automatic backend_redirect_flush();
	redirect_to(RESET_PC + 32'h30c, 1'b0, '0, '0);
	// First packet after the pulse already comes from the new path
	expect_packet(RESET_PC + 32'h30c, 1'b0, 1'b0, '0);
	expect_packet(RESET_PC + 32'h310, 1'b0, 1'b0, '0);
endtask

`endif

//--- test/tb_fetch_frontend.sv
// ========================================
// Testbench of the two-wide fetch front end
// Clock, reset, instruction memory model,
// watchdog and the directed test sequence
// ========================================
`timescale 1ns/1ps

module tb_fetch_frontend;

	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	// ========================================
	// Run length
	// ========================================
	localparam int RESET_CYCLES = 16;
	// Generous budget of all directed tests
	localparam int TEST_CYCLES  = 160;
	// Longest wait for one packet
	localparam int PKT_WAIT     = 24;

	// Addresses used by the tests
	localparam addr_t BR_PC     = RESET_PC + 32'h100;
	localparam addr_t BR_TARGET = RESET_PC + 32'h204;
	// Same table index and slot as BR_PC
	localparam addr_t ALIAS_PC  = RESET_PC + 32'h240;
	localparam addr_t PLAIN_PC  = RESET_PC + 32'h148;
	localparam addr_t SNAP_PC   = RESET_PC + 32'h188;

	logic           clk;
	logic           rst_n_i;
	inst_pair_t     imem_data_i;
	logic           stall_i;
	logic           bk_redirect_i;
	addr_t          bk_target_i;
	logic           bk_train_i;
	addr_t          bk_train_pc_i;
	addr_t          bk_train_target_i;
	logic           bk_call_i;
	logic           bk_ret_i;
	addr_t          imem_addr_o;
	decode_packet_t dec_packet_o;
	ras_ptr_t       ras_ptr_o;

	// 1 KB program image, word indexed
	inst_t    mem [256];
	int       seed;
	int       checks;
	int       errors;
	// Expected return stack pointer
	ras_ptr_t ras_model;

	fetch_frontend u_dut (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.imem_data_i       (imem_data_i),
		.stall_i           (stall_i),
		.bk_redirect_i     (bk_redirect_i),
		.bk_target_i       (bk_target_i),
		.bk_train_i        (bk_train_i),
		.bk_train_pc_i     (bk_train_pc_i),
		.bk_train_target_i (bk_train_target_i),
		.bk_call_i         (bk_call_i),
		.bk_ret_i          (bk_ret_i),
		.imem_addr_o       (imem_addr_o),
		.dec_packet_o      (dec_packet_o),
		.ras_ptr_o         (ras_ptr_o)
	);

	`include "tb_fetch_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Synchronous memory, answers one cycle after the address
	always @(posedge clk) begin
		imem_data_i[0] <= mem[imem_addr_o[9:2]];
		imem_data_i[1] <= mem[imem_addr_o[9:2] + 8'd1];
	end

	// Watchdog
	initial begin
		#((RESET_CYCLES + TEST_CYCLES + 200) * 100);
		$display("Watchdog expired before the test sequence completed");
		$display("Simulation failed");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		rst_n_i           = 1'b0;
		imem_data_i       = '0;
		stall_i           = 1'b0;
		bk_redirect_i     = 1'b0;
		bk_target_i       = '0;
		bk_train_i        = 1'b0;
		bk_train_pc_i     = '0;
		bk_train_target_i = '0;
		bk_call_i         = 1'b0;
		bk_ret_i          = 1'b0;
		checks            = 0;
		errors            = 0;
		ras_model         = '0;
		seed              = 32'hab79;
		load_program();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n_i = 1'b1;

		sequential_fetch();
		taken_prediction();
		false_taken_drop();
		ras_pointer_restore();
		stall_hold();
		backend_redirect_flush();

		$display("Closing summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+test
source/fetch_cfg_pkg.sv
source/fetch_types_pkg.sv
source/fetch_pc_gen.sv
source/branch_predictor.sv
source/predecoder.sv
source/pre_checker.sv
source/fetch_buffer.sv
source/fetch_frontend.sv
test/tb_fetch_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
	--top-module tb_fetch_frontend -o sim_fetch
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation binary exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1
